//--- front_end_config.svh
`ifndef FRONT_END_CONFIG_SVH
`define FRONT_END_CONFIG_SVH

// ==================================================
// Datapath widths
// ==================================================

// Address and fetch word width
`define FE_XLEN 32

// One RISC-V parcel, the unit of compressed code
`define FE_HALF 16

// ==================================================
// Fetch configuration
// ==================================================

// Instruction buffer depth in entries and always a power of two
`define FE_IBUF_DEPTH 8

// First fetch address after reset
`define FE_RESET_PC 32'h0000_0000

`endif

//--- front_end_pkg.sv
`include "front_end_config.svh"

package front_end_pkg;

    // Byte address of a fetch or of an instruction
    typedef logic [`FE_XLEN-1:0] addr_t;

    // One 16-bit instruction parcel
    typedef logic [`FE_HALF-1:0] half_t;

    // A fetched memory word
    // The aligner reads it whole for aligned full instructions and
    // as two parcels when it splits compressed or crossing code
    typedef union packed {
        logic [`FE_XLEN-1:0] raw;
        struct packed {
            half_t upper_half;
            half_t lower_half;
        } halves;
    } fetch_word_u;

endpackage : front_end_pkg

//--- front_end_if.sv
`timescale 1ns/1ps

// Write side of the instruction buffer, driven by the fetch unit
interface ibuf_write_if;
    import front_end_pkg::*;

    logic        push;
    fetch_word_u word;
    addr_t       addr;
    logic        full;
    logic        flush;

    modport producer (output push, output word, output addr, output flush, input full);
    modport consumer (input push, input word, input addr, input flush, output full);

endinterface : ibuf_write_if

// Read side of the instruction buffer, drained by the aligner
interface ibuf_read_if;
    import front_end_pkg::*;

    logic        empty;
    logic        pop;
    fetch_word_u word;
    addr_t       addr;

    // Redirect flush, forwarded so the aligner clears with the buffer
    logic        flush;

    modport producer (output empty, output word, output addr, output flush, input pop);
    modport consumer (input empty, input word, input addr, input flush, output pop);

endinterface : ibuf_read_if

//--- fetch_unit.sv
`timescale 1ns/1ps
`include "front_end_config.svh"

module fetch_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 trap_i,
    input  logic                 branch_taken_i,
    input  front_end_pkg::addr_t trap_pc_i,
    input  front_end_pkg::addr_t branch_target_i,
    output logic                 mem_req_o,
    output front_end_pkg::addr_t mem_addr_o,
    input  logic                 mem_ack_i,
    input  logic [`FE_XLEN-1:0]  mem_data_i,
    ibuf_write_if.producer       wr
);
    import front_end_pkg::*;

    localparam logic [1:0] HS_IDLE         = 2'd0;
    localparam logic [1:0] HS_WAIT_ACK     = 2'd1;
    localparam logic [1:0] HS_WAIT_RELEASE = 2'd2;

    logic [1:0] hs_state;
    addr_t      pc;
    addr_t      fetch_addr;
    addr_t      redirect_pc;
    logic       redirect;
    logic       stale;
    logic       halted;
    logic       issue;
    logic       fetch_push;
    logic       misaligned_push;

    // ==================================================
    // Next fetch address
    // ==================================================

    // A trap wins over a resolved branch and both win over sequential fetch
    assign redirect    = trap_i | branch_taken_i;
    assign redirect_pc = trap_i ? trap_pc_i : branch_target_i;

    // Only one handshake is ever open, so a free slot at issue time is
    // still free when the word comes back
    assign issue = (hs_state == HS_IDLE) && !redirect && !halted && !pc[0] && !wr.full;

    assign fetch_push = (hs_state == HS_WAIT_ACK) && mem_ack_i && !stale && !redirect;

    // An odd target never reaches memory and travels as a marker entry
    assign misaligned_push = pc[0] && !halted && !redirect && !wr.full;

    always_ff @(posedge clk_i) begin : program_counter
        if (!rst_n_i) begin
            pc     <= `FE_RESET_PC;
            halted <= 1'b0;
        end else if (redirect) begin
            pc     <= redirect_pc;
            halted <= 1'b0;
        end else if (fetch_push) begin
            pc <= {pc[`FE_XLEN-1:2], 2'b00} + addr_t'(4);
        end else if (misaligned_push) begin
            halted <= 1'b1;
        end
    end : program_counter

    // ==================================================
    // Four-phase memory handshake
    // ==================================================

    always_ff @(posedge clk_i) begin : handshake_fsm
        if (!rst_n_i) begin
            hs_state <= HS_IDLE;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (issue) begin
                        hs_state <= HS_WAIT_ACK;
                    end
                end
                HS_WAIT_ACK: begin
                    if (mem_ack_i) begin
                        hs_state <= HS_WAIT_RELEASE;
                    end
                end
                HS_WAIT_RELEASE: begin
                    if (!mem_ack_i) begin
                        hs_state <= HS_IDLE;
                    end
                end
                default: begin
                    hs_state <= HS_IDLE;
                end
            endcase
        end
    end : handshake_fsm

    // A redirect while waiting turns the pending word into garbage
    always_ff @(posedge clk_i) begin : stale_flag
        if (!rst_n_i) begin
            stale <= 1'b0;
        end else if (issue) begin
            stale <= 1'b0;
        end else if (redirect && (hs_state == HS_WAIT_ACK)) begin
            stale <= 1'b1;
        end
    end : stale_flag

    // Keeps bit 1 of the PC so the buffer entry knows its start parcel
    always_ff @(posedge clk_i) begin
        if (issue) begin
            fetch_addr <= pc;
        end
    end

    assign mem_req_o  = (hs_state == HS_WAIT_ACK);
    assign mem_addr_o = {fetch_addr[`FE_XLEN-1:2], 2'b00};

    assign wr.push  = fetch_push | misaligned_push;
    assign wr.word  = misaligned_push ? fetch_word_u'('0) : fetch_word_u'(mem_data_i);
    assign wr.addr  = misaligned_push ? pc : fetch_addr;
    assign wr.flush = redirect;

    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o));

    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr.push |-> !wr.full);

endmodule : fetch_unit

//--- instruction_buffer.sv
`timescale 1ns/1ps
`include "front_end_config.svh"

module instruction_buffer #(
    parameter int DEPTH = `FE_IBUF_DEPTH
) (
    input logic            clk_i,
    input logic            rst_n_i,
    ibuf_write_if.consumer wr,
    ibuf_read_if.producer  rd
);
    import front_end_pkg::*;

    localparam int               PTR_W      = $clog2(DEPTH);
    localparam logic [PTR_W:0]   FULL_COUNT = (PTR_W + 1)'(DEPTH);

    fetch_word_u      word_mem [DEPTH];
    addr_t            addr_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // Flush beats both push and pop on the same edge
    assign do_push = wr.push && !wr.flush;
    assign do_pop  = rd.pop && !wr.flush;

    // The count rule says full means no slot is free. The fetch unit keeps at most
    // one word in flight and opens a handshake only while full is low, so
    // the slot it saw free is still free when the word is pushed
    assign wr.full  = (count == FULL_COUNT);
    assign rd.empty = (count == '0);

    always_ff @(posedge clk_i) begin : pointers
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (wr.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end : pointers

    always_ff @(posedge clk_i) begin : storage
        if (do_push) begin
            word_mem[wr_ptr] <= wr.word;
            addr_mem[wr_ptr] <= wr.addr;
        end
    end : storage

    // Head entry is visible whenever the buffer is not empty
    assign rd.word  = word_mem[rd_ptr];
    assign rd.addr  = addr_mem[rd_ptr];
    assign rd.flush = wr.flush;

    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        do_push && !do_pop |-> !wr.full);

    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd.pop |-> !rd.empty);

endmodule : instruction_buffer

//--- instruction_aligner.sv
`timescale 1ns/1ps
`include "front_end_config.svh"

module instruction_aligner (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    ibuf_read_if.consumer        rd,
    output logic                 instr_valid_o,
    output logic                 instr_compressed_o,
    output logic                 instr_exception_o,
    output logic [`FE_XLEN-1:0]  instr_o,
    output front_end_pkg::addr_t instr_pc_o
);
    import front_end_pkg::*;

    // Realignment state
    half_t upper_q;
    logic  cross_q;
    logic  sel_upper_q;
    logic  halt_q;

    logic                advance;
    logic                sel_upper;
    half_t               cur_half;
    addr_t               word_pc;
    logic                emit;
    logic                emit_compressed;
    logic                emit_exception;
    logic [`FE_XLEN-1:0] emit_instr;
    addr_t               emit_pc;
    logic                step_pop;
    logic                save_upper;
    logic                next_cross;
    logic                next_sel_upper;

    // Full-length parcels have both low bits set
    function automatic logic is_full_length(input half_t parcel);
        return (parcel[1:0] == 2'b11);
    endfunction

    assign advance = !stall_i && !rd.flush;

    // A redirect to an upper parcel starts with the lower half already spent
    assign sel_upper = sel_upper_q | rd.addr[1];
    assign cur_half  = sel_upper ? rd.word.halves.upper_half : rd.word.halves.lower_half;
    assign word_pc   = {rd.addr[`FE_XLEN-1:2], 2'b00};

    // ==================================================
    // One parcel step per cycle
    // ==================================================

    always_comb begin : step_decode
        emit            = 1'b0;
        emit_compressed = 1'b0;
        emit_exception  = 1'b0;
        emit_instr      = '0;
        emit_pc         = word_pc;
        step_pop        = 1'b0;
        save_upper      = 1'b0;
        next_cross      = cross_q;
        next_sel_upper  = sel_upper_q;

        if (!halt_q && !rd.empty) begin
            if (rd.addr[0]) begin
                // Report an odd target once and then go quiet
                emit           = 1'b1;
                emit_exception = 1'b1;
                emit_pc        = rd.addr;
                step_pop       = 1'b1;
            end else if (cross_q) begin
                // Earlier parcel is the low half of the crossing instruction
                emit           = 1'b1;
                emit_instr     = {rd.word.halves.lower_half, upper_q};
                emit_pc        = word_pc - addr_t'(2);
                next_cross     = 1'b0;
                next_sel_upper = 1'b1;
            end else if (sel_upper) begin
                step_pop       = 1'b1;
                next_sel_upper = 1'b0;
                if (is_full_length(cur_half)) begin
                    save_upper = 1'b1;
                    next_cross = 1'b1;
                end else begin
                    emit            = 1'b1;
                    emit_compressed = 1'b1;
                    emit_instr      = {{(`FE_XLEN - `FE_HALF){1'b0}}, cur_half};
                    emit_pc         = word_pc + addr_t'(2);
                end
            end else if (is_full_length(cur_half)) begin
                emit       = 1'b1;
                emit_instr = rd.word.raw;
                step_pop   = 1'b1;
            end else begin
                emit            = 1'b1;
                emit_compressed = 1'b1;
                emit_instr      = {{(`FE_XLEN - `FE_HALF){1'b0}}, cur_half};
                next_sel_upper  = 1'b1;
            end
        end
    end : step_decode

    assign rd.pop = advance && step_pop;

    always_ff @(posedge clk_i) begin : align_state
        if (!rst_n_i) begin
            cross_q     <= 1'b0;
            sel_upper_q <= 1'b0;
            halt_q      <= 1'b0;
        end else if (rd.flush) begin
            cross_q     <= 1'b0;
            sel_upper_q <= 1'b0;
            halt_q      <= 1'b0;
        end else if (advance) begin
            cross_q     <= next_cross;
            sel_upper_q <= next_sel_upper;
            halt_q      <= halt_q | emit_exception;
        end
    end : align_state

    always_ff @(posedge clk_i) begin
        if (advance && save_upper) begin
            upper_q <= cur_half;
        end
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge clk_i) begin : output_valid
        if (!rst_n_i) begin
            instr_valid_o <= 1'b0;
        end else if (rd.flush) begin
            instr_valid_o <= 1'b0;
        end else if (advance) begin
            instr_valid_o <= emit;
        end
    end : output_valid

    always_ff @(posedge clk_i) begin : output_payload
        if (advance && emit) begin
            instr_o            <= emit_instr;
            instr_pc_o         <= emit_pc;
            instr_compressed_o <= emit_compressed;
            instr_exception_o  <= emit_exception;
        end
    end : output_payload

    a_valid_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(instr_valid_o));

endmodule : instruction_aligner

//--- front_end.sv
`timescale 1ns/1ps
`include "front_end_config.svh"

module front_end (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Redirects from the back end
    input  logic                 trap_i,
    input  front_end_pkg::addr_t trap_pc_i,
    input  logic                 branch_taken_i,
    input  front_end_pkg::addr_t branch_target_i,

    // Instruction memory, four-phase req/ack
    output logic                 mem_req_o,
    output front_end_pkg::addr_t mem_addr_o,
    input  logic                 mem_ack_i,
    input  logic [`FE_XLEN-1:0]  mem_data_i,

    // Instruction stream to the back end
    input  logic                 stall_i,
    output logic                 instr_valid_o,
    output logic [`FE_XLEN-1:0]  instr_o,
    output front_end_pkg::addr_t instr_pc_o,
    output logic                 instr_compressed_o,
    output logic                 instr_exception_o
);

    ibuf_write_if ibuf_wr ();
    ibuf_read_if  ibuf_rd ();

    fetch_unit i_fetch_unit (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .trap_i          ( trap_i          ),
        .branch_taken_i  ( branch_taken_i  ),
        .trap_pc_i       ( trap_pc_i       ),
        .branch_target_i ( branch_target_i ),
        .mem_req_o       ( mem_req_o       ),
        .mem_addr_o      ( mem_addr_o      ),
        .mem_ack_i       ( mem_ack_i       ),
        .mem_data_i      ( mem_data_i      ),
        .wr              ( ibuf_wr         )
    );

    instruction_buffer #(
        .DEPTH ( `FE_IBUF_DEPTH )
    ) i_instruction_buffer (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .wr      ( ibuf_wr ),
        .rd      ( ibuf_rd )
    );

    instruction_aligner i_instruction_aligner (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .stall_i            ( stall_i            ),
        .rd                 ( ibuf_rd            ),
        .instr_valid_o      ( instr_valid_o      ),
        .instr_compressed_o ( instr_compressed_o ),
        .instr_exception_o  ( instr_exception_o  ),
        .instr_o            ( instr_o            ),
        .instr_pc_o         ( instr_pc_o         )
    );

endmodule : front_end

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset is released on a falling edge like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

//--- tb_front_end.sv
`timescale 1ns/1ps
`include "front_end_config.svh"

module tb_front_end;

    localparam int CYCLES_PER_INSTR = 40;
    localparam int CYCLE_MARGIN     = 200;

    // Stall hold long enough to fill the buffer at six cycles per handshake
    localparam int HOLD_CYCLES      = (`FE_IBUF_DEPTH + 2) * 6;

    logic        clk_i;
    logic        rst_n_i;
    logic        trap_i;
    logic [31:0] trap_pc_i;
    logic        branch_taken_i;
    logic [31:0] branch_target_i;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic        mem_ack_i;
    logic [31:0] mem_data_i;
    logic        stall_i;
    logic        instr_valid_o;
    logic [31:0] instr_o;
    logic [31:0] instr_pc_o;
    logic        instr_compressed_o;
    logic        instr_exception_o;

    // Stimulus tables
    logic [31:0] mem [logic [31:0]];
    int          exp_test [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_instr [$];
    logic        exp_c [$];
    logic        exp_x [$];
    int          ev_kind [$];
    logic [31:0] ev_trap [$];
    logic [31:0] ev_branch [$];
    int          ev_count [$];

    int   accepted;
    int   ev_idx;
    int   hold;
    int   test_errors;
    int   total_errors;
    int   cycles;
    int   mem_wait;
    int   limit;
    logic quiet;

    tb_clock_gen i_clock_gen (
        .clk_o   ( clk_i   ),
        .rst_n_o ( rst_n_i )
    );

    front_end i_front_end (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .trap_i             ( trap_i             ),
        .trap_pc_i          ( trap_pc_i          ),
        .branch_taken_i     ( branch_taken_i     ),
        .branch_target_i    ( branch_target_i    ),
        .mem_req_o          ( mem_req_o          ),
        .mem_addr_o         ( mem_addr_o         ),
        .mem_ack_i          ( mem_ack_i          ),
        .mem_data_i         ( mem_data_i         ),
        .stall_i            ( stall_i            ),
        .instr_valid_o      ( instr_valid_o      ),
        .instr_o            ( instr_o            ),
        .instr_pc_o         ( instr_pc_o         ),
        .instr_compressed_o ( instr_compressed_o ),
        .instr_exception_o  ( instr_exception_o  )
    );

    task automatic load_stimulus(output bit ok);
        int          fd;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          t;
        int          k;
        int          n;
        int          x;
        ok = 1'b0;
        fd = $fopen("front_end_stimulus.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) == "M") begin
                    n = $sscanf(line, "M %h %h", a, b);
                    ok = ok && (n == 2);
                    mem[a] = b;
                end else if (line.len() > 0 && line.getc(0) == "E") begin
                    n = $sscanf(line, "E %d %h %h %d %d", t, a, b, k, x);
                    ok = ok && (n == 5);
                    exp_test.push_back(t);
                    exp_pc.push_back(a);
                    exp_instr.push_back(b);
                    exp_c.push_back(k[0]);
                    exp_x.push_back(x[0]);
                end else if (line.len() > 0 && line.getc(0) == "R") begin
                    n = $sscanf(line, "R %d %h %h %d", k, a, c, t);
                    ok = ok && (n == 4);
                    ev_kind.push_back(k);
                    ev_trap.push_back(a);
                    ev_branch.push_back(c);
                    ev_count.push_back(t);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // Compares one accepted instruction and closes its test when it was the last
    task automatic check_accepted();
        int i;
        i = accepted;
        check_value("instr_pc_o", instr_pc_o, exp_pc[i]);
        check_value("instr_o", instr_o, exp_instr[i]);
        check_value("instr_compressed_o", 32'(instr_compressed_o), 32'(exp_c[i]));
        check_value("instr_exception_o", 32'(instr_exception_o), 32'(exp_x[i]));
        if (exp_x[i]) begin
            quiet = 1'b1;
        end
        accepted++;
        if (accepted == exp_pc.size() || exp_test[accepted] != exp_test[i]) begin
            $display("Test %0d finished with %0d errors", exp_test[i], test_errors);
            total_errors += test_errors;
            test_errors = 0;
        end
    endtask

    // Memory model answers each request after 0 to 3 cycles
    always @(negedge clk_i) begin : memory_model
        if (mem_ack_i && !mem_req_o) begin
            mem_ack_i <= 1'b0;
        end else if (mem_req_o && !mem_ack_i) begin
            if (mem_wait < 0) begin
                mem_wait = int'($urandom % 4);
            end
            if (mem_wait == 0) begin
                mem_ack_i  <= 1'b1;
                // Unlisted words get a filler tied to the full address
                mem_data_i <= mem.exists(mem_addr_o) ? mem[mem_addr_o]
                                                     : {mem_addr_o[31:2], 2'b11};
                mem_wait = -1;
            end else begin
                mem_wait--;
            end
        end
    end : memory_model

    always @(posedge clk_i) begin : watchdog
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
                     cycles, accepted, exp_pc.size());
            $display("Done: errors found");
            $finish;
        end
    end : watchdog

    initial begin : stimulus
        int unused;
        bit loaded;
        unused          = $urandom(32'hd71d54a1);
        trap_i          = 1'b0;
        trap_pc_i       = '0;
        branch_taken_i  = 1'b0;
        branch_target_i = '0;
        mem_ack_i       = 1'b0;
        mem_data_i      = '0;
        stall_i         = 1'b0;
        accepted        = 0;
        ev_idx          = 0;
        hold            = 0;
        test_errors     = 0;
        total_errors    = 0;
        cycles          = 0;
        mem_wait        = -1;
        quiet           = 1'b0;
        limit           = CYCLE_MARGIN;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("Cannot read front_end_stimulus.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            limit = CYCLES_PER_INSTR * exp_pc.size() + CYCLE_MARGIN;
            wait (rst_n_i);

            while (accepted < exp_pc.size()) begin
                @(negedge clk_i);
                trap_i         = 1'b0;
                branch_taken_i = 1'b0;
                // After a misaligned target nothing may show until the next redirect
                if (quiet) begin
                    assert (!instr_valid_o) else begin
                        $display("Instruction shown at %0t ns after a misaligned target",
                                 $time);
                        total_errors++;
                    end
                end
                if (ev_idx < ev_kind.size() && accepted == ev_count[ev_idx]) begin
                    // Kind 0 holds stall while bit 0 fires a branch and bit 1 a trap
                    if (ev_kind[ev_idx] == 0) begin
                        hold = HOLD_CYCLES;
                    end else begin
                        quiet = 1'b0;
                    end
                    branch_taken_i  = ev_kind[ev_idx][0];
                    trap_i          = ev_kind[ev_idx][1];
                    trap_pc_i       = ev_trap[ev_idx];
                    branch_target_i = ev_branch[ev_idx];
                    stall_i         = 1'b1;
                    ev_idx++;
                end else if (hold > 0) begin
                    stall_i = 1'b1;
                    hold--;
                end else begin
                    stall_i = ($urandom % 4) == 0;
                end
                // Outputs are settled here, so acceptance at the next edge is known
                if (instr_valid_o && !stall_i) begin
                    check_accepted();
                end
            end

            @(negedge clk_i);
            $display("Checked %0d instructions, %0d errors", accepted, total_errors);
            if (total_errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end : stimulus

endmodule : tb_front_end

//--- files.f
+incdir+.
front_end_pkg.sv
front_end_if.sv
fetch_unit.sv
instruction_buffer.sv
instruction_aligner.sv
front_end.sv
tb_clock_gen.sv
tb_front_end.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_front_end
FILELIST   ?= files.f
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- front_end_stimulus.txt
# M address data | E test pc instr compressed exception
# R kind(0 stall hold, 1 branch, 2 trap, 3 both) trap_pc branch_target after_count
M 00000000 00100093
M 00000004 00200113
M 00000008 00300193
M 0000000c 00400213
M 00000010 05934505
M 00000014 808200a5
M 00000018 00b00313
M 0000001c 46014581
M 00000040 47054701
M 00000044 00c00393
M 00000060 0ff00513
M 00000080 00d00413
M 00000084 00e00493
M 000000c0 00100013
M 000000c4 00200013
M 000000c8 00300013
M 000000cc 00400013
M 000000d0 00500013
M 000000d4 00600013
M 000000d8 00700013
M 000000dc 00800013
M 000000e0 00900013
M 000000e4 00a00013
M 000000e8 00b00013
M 000000ec 00c00013
E 1 00000000 00100093 0 0
E 1 00000004 00200113 0 0
E 1 00000008 00300193 0 0
E 1 0000000c 00400213 0 0
E 2 00000010 00004505 1 0
E 2 00000012 00a50593 0 0
E 2 00000016 00008082 1 0
E 2 00000018 00b00313 0 0
E 2 0000001c 00004581 1 0
E 2 0000001e 00004601 1 0
R 1 00000000 00000042 10
E 3 00000042 00004705 1 0
E 3 00000044 00c00393 0 0
R 3 00000080 00000060 12
E 4 00000080 00d00413 0 0
E 4 00000084 00e00493 0 0
R 1 00000000 00000101 14
E 5 00000101 00000000 0 1
R 1 00000000 000000c0 15
E 6 000000c0 00100013 0 0
E 6 000000c4 00200013 0 0
R 0 00000000 00000000 17
E 6 000000c8 00300013 0 0
E 6 000000cc 00400013 0 0
E 6 000000d0 00500013 0 0
E 6 000000d4 00600013 0 0
E 6 000000d8 00700013 0 0
E 6 000000dc 00800013 0 0
E 6 000000e0 00900013 0 0
E 6 000000e4 00a00013 0 0
E 6 000000e8 00b00013 0 0
E 6 000000ec 00c00013 0 0
